/* hw/cps_video_pkg.sv */
package cps_video_pkg;

    // Raster timing, one pixel per clock
    localparam int h_total   = 512;
    localparam int h_active  = 384;
    localparam int hs_start  = 432;
    localparam int hs_end    = 464;
    localparam int v_total   = 262;
    localparam int v_active  = 224;
    localparam int vs_start  = 240;
    localparam int vs_end    = 243;

    // Mixer, palette read and RGB register
    localparam int blank_dly = 3;

    typedef logic [8:0]  scan_t;
    typedef logic [7:0]  layer_pxl_t;
    typedef logic [1:0]  layer_id_t;
    typedef logic [9:0]  pal_addr_t;
    typedef logic [15:0] pal_word_t;
    typedef logic [7:0]  colour_t;
    typedef logic [3:0]  reg_addr_t;

    // Colour code that lets the layer below show through
    localparam logic [3:0] transparent = 4'hf;
    localparam pal_addr_t  backdrop_addr = 10'h3ff;

    // Register map and power-up values
    localparam reg_addr_t  reg_layer_ctrl = 4'd0;
    localparam reg_addr_t  reg_layer_en   = 4'd1;
    localparam logic [7:0] layer_ctrl_rst = 8'b11_10_01_00;
    localparam logic [3:0] layer_en_rst   = 4'b1111;

    typedef enum logic {
        reg_space,
        pal_space
    } cpu_target_e;

    typedef struct packed {
        logic        wr;
        cpu_target_e target;
        logic [9:0]  addr;
        pal_word_t   data;
    } cpu_wr_t;

    typedef struct packed {
        layer_pxl_t obj;
        layer_pxl_t scr1;
        layer_pxl_t scr2;
        layer_pxl_t scr3;
    } layer_set_t;

    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } video_sync_t;

    typedef struct packed {
        colour_t red;
        colour_t green;
        colour_t blue;
    } rgb_t;

endpackage

/* hw/cps_video_timing.sv */
`timescale 1ns/1ns

module cps_video_timing (
    input  logic                       clk,
    input  logic                       rst,
    output cps_video_pkg::scan_t       hdump,
    output cps_video_pkg::scan_t       vdump,
    output cps_video_pkg::video_sync_t sync
);
    import cps_video_pkg::*;

    scan_t h_nxt;
    scan_t v_nxt;
    logic  line_end;
    logic  frame_end;

    assign line_end  = hdump == scan_t'(h_total - 1);
    assign frame_end = vdump == scan_t'(v_total - 1);

    // Next raster position
    always_comb begin
        if (line_end) begin
            h_nxt = '0;
        end else begin
            h_nxt = hdump + 1'b1;
        end

        v_nxt = vdump;
        if (line_end) begin
            if (frame_end) begin
                v_nxt = '0;
            end else begin
                v_nxt = vdump + 1'b1;
            end
        end
    end

    // Windows decoded from the next position so they line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            sync  <= '0;
        end else begin
            hdump   <= h_nxt;
            vdump   <= v_nxt;
            sync.hb <= h_nxt >= h_active;
            sync.vb <= v_nxt >= v_active;
            // Sync end bounds are exclusive
            sync.hs <= (h_nxt >= hs_start) && (h_nxt < hs_end);
            sync.vs <= (v_nxt >= vs_start) && (v_nxt < vs_end);
        end
    end

endmodule

/* hw/cps_mmr.sv */
`timescale 1ns/1ns

module cps_mmr (
    input  logic                     clk,
    input  logic                     rst,
    input  cps_video_pkg::cpu_wr_t   cpu,
    input  cps_video_pkg::reg_addr_t rd_addr,
    output cps_video_pkg::pal_word_t mmr_dout,
    output logic [7:0]               layer_ctrl,
    output logic [3:0]               layer_en
);
    import cps_video_pkg::*;

    logic      reg_we;
    reg_addr_t wr_idx;

    assign reg_we = cpu.wr && (cpu.target == reg_space);
    assign wr_idx = cpu.addr[3:0];

    // Write side, one strobe is one complete write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl <= layer_ctrl_rst;
            layer_en   <= layer_en_rst;
        end else if (reg_we) begin
            case (wr_idx)
                reg_layer_ctrl: begin
                    layer_ctrl <= cpu.data[7:0];
                end
                reg_layer_en: begin
                    layer_en <= cpu.data[3:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Readback, unmapped indices read as zero
    always_comb begin
        case (rd_addr)
            reg_layer_ctrl: mmr_dout = {8'h00, layer_ctrl};
            reg_layer_en:   mmr_dout = {12'h000, layer_en};
            default:        mmr_dout = '0;
        endcase
    end

endmodule

/* hw/cps_colmix.sv */
`timescale 1ns/1ns

module cps_colmix (
    input  logic                     clk,
    input  logic                     rst,
    input  cps_video_pkg::layer_set_t layers,
    input  logic [7:0]               layer_ctrl,
    input  logic [3:0]               layer_en,
    output cps_video_pkg::pal_addr_t pal_addr
);
    import cps_video_pkg::*;

    layer_pxl_t by_id [4];
    pal_addr_t  merged;

    // Pixels indexed by layer number
    assign by_id[0] = layers.obj;
    assign by_id[1] = layers.scr1;
    assign by_id[2] = layers.scr2;
    assign by_id[3] = layers.scr3;

    // Field 3 of layer_ctrl is the top of the stack, field 0 the bottom
    always_comb begin : pick_layer
        layer_id_t id;
        logic      found;

        merged = backdrop_addr;
        found  = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            id = layer_ctrl[2*i +: 2];
            // First enabled, opaque layer from the top wins
            if (!found && layer_en[id] && (by_id[id][3:0] != transparent)) begin
                merged = {id, by_id[id]};
                found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_addr <= backdrop_addr;
        end else begin
            pal_addr <= merged;
        end
    end

endmodule

/* hw/cps_pal.sv */
`timescale 1ns/1ns

module cps_pal (
    input  logic                       clk,
    input  logic                       rst,
    input  cps_video_pkg::cpu_wr_t     cpu,
    input  cps_video_pkg::pal_addr_t   pal_addr,
    input  cps_video_pkg::video_sync_t sync,
    output cps_video_pkg::rgb_t        rgb,
    output logic                       lhbl,
    output logic                       lvbl
);
    import cps_video_pkg::*;

    pal_word_t            ram [0:(1 << $bits(pal_addr_t)) - 1];
    pal_word_t            pal_q;
    rgb_t                 rgb_q;
    logic [blank_dly-1:0] hb_dly;
    logic [blank_dly-1:0] vb_dly;
    logic                 blank;

    // Channel times (16 + brightness), halved
    function automatic colour_t scale(input logic [3:0] chan, input logic [3:0] bright);
        logic [8:0] prod;

        prod = 9'(chan) * (9'd16 + 9'(bright));
        return prod[8:1];
    endfunction

    // CPU write port and video read port
    always_ff @(posedge clk) begin
        if (cpu.wr && (cpu.target == pal_space)) begin
            ram[cpu.addr] <= cpu.data;
        end
        pal_q <= ram[pal_addr];
    end

    // Entry layout is brightness, red, green, blue from the top nibble
    always_ff @(posedge clk) begin
        rgb_q.red   <= scale(pal_q[11:8], pal_q[15:12]);
        rgb_q.green <= scale(pal_q[7:4], pal_q[15:12]);
        rgb_q.blue  <= scale(pal_q[3:0], pal_q[15:12]);
    end

    // Blanks follow the pixel through mixer, RAM and RGB stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hb_dly <= '1;
            vb_dly <= '1;
        end else begin
            hb_dly <= {hb_dly[blank_dly-2:0], sync.hb};
            vb_dly <= {vb_dly[blank_dly-2:0], sync.vb};
        end
    end

    assign blank = hb_dly[blank_dly-1] | vb_dly[blank_dly-1];
    assign lhbl  = ~hb_dly[blank_dly-1];
    assign lvbl  = ~vb_dly[blank_dly-1];
    assign rgb   = blank ? '0 : rgb_q;

endmodule

/* hw/cps_video.sv */
`timescale 1ns/1ns

module cps_video (
    input  logic                       clk,
    input  logic                       rst,
    input  cps_video_pkg::cpu_wr_t     cpu,
    input  cps_video_pkg::reg_addr_t   rd_addr,
    output cps_video_pkg::pal_word_t   mmr_dout,
    input  cps_video_pkg::layer_set_t  layers,
    output cps_video_pkg::scan_t       hdump,
    output cps_video_pkg::scan_t       vdump,
    output logic                       hs,
    output logic                       vs,
    output logic                       lhbl,
    output logic                       lvbl,
    output cps_video_pkg::rgb_t        rgb
);
    import cps_video_pkg::*;

    video_sync_t sync;
    logic [7:0]  layer_ctrl;
    logic [3:0]  layer_en;
    pal_addr_t   pal_addr;

    // Sync pulses leave straight from the raster counters
    assign hs = sync.hs;
    assign vs = sync.vs;

    cps_video_timing u_timing (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .hdump      ( hdump      ),
        .vdump      ( vdump      ),
        .sync       ( sync       )
    );

    cps_mmr u_mmr (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu        ( cpu        ),
        .rd_addr    ( rd_addr    ),
        .mmr_dout   ( mmr_dout   ),
        .layer_ctrl ( layer_ctrl ),
        .layer_en   ( layer_en   )
    );

    cps_colmix u_colmix (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .layers     ( layers     ),
        .layer_ctrl ( layer_ctrl ),
        .layer_en   ( layer_en   ),
        .pal_addr   ( pal_addr   )
    );

    cps_pal u_pal (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu        ( cpu        ),
        .pal_addr   ( pal_addr   ),
        .sync       ( sync       ),
        .rgb        ( rgb        ),
        .lhbl       ( lhbl       ),
        .lvbl       ( lvbl       )
    );

endmodule

/* verif/cps_video_tb.sv */
`timescale 1ns/1ns

module cps_video_tb;
    import cps_video_pkg::*;

    // One parsed line of the tests file
    typedef struct packed {
        logic [7:0]       op;
        logic [6:0][31:0] f;
    } step_t;

    logic       clk;
    logic       rst;
    cpu_wr_t    cpu;
    reg_addr_t  rd_addr;
    pal_word_t  mmr_dout;
    layer_set_t layers;
    scan_t      hdump;
    scan_t      vdump;
    logic       hs;
    logic       vs;
    logic       lhbl;
    logic       lvbl;
    rgb_t       rgb;

    step_t steps[$];
    int    cycle_cnt;
    int    cycle_limit;
    logic  limit_ready = 1'b0;

    cps_video DUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu      ( cpu      ),
        .rd_addr  ( rd_addr  ),
        .mmr_dout ( mmr_dout ),
        .layers   ( layers   ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .rgb      ( rgb      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic word_check(input string name, input pal_word_t exp, input pal_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic rgb_check(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic count_check(input string name, input scan_t exp, input scan_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          ch;
        int          n;
        int          want;
        step_t       s;
        logic [31:0] v0, v1, v2, v3, v4, v5, v6;

        fd = $fopen("verif/cps_video_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file verif/cps_video_tests.txt");
            abort_run();
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != -1 && ch != "\n") begin
                    ch = $fgetc(fd);
                end
            end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                {v0, v1, v2, v3, v4, v5, v6} = '0;
                n    = 0;
                want = 0;
                s    = '0;
                s.op = 8'(ch);
                case (s.op)
                    "W": begin
                        want = 3;
                        n = $fscanf(fd, "%h %h %h", v0, v1, v2);
                    end
                    "R": begin
                        want = 2;
                        n = $fscanf(fd, "%h %h", v0, v1);
                    end
                    "P": begin
                        want = 7;
                        n = $fscanf(fd, "%h %h %h %h %h %h %h", v0, v1, v2, v3, v4, v5, v6);
                    end
                    "F": begin
                        want = 6;
                        n = $fscanf(fd, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
                    end
                    default: begin
                        $display("Unknown opcode %c in the tests file", s.op);
                        abort_run();
                    end
                endcase
                if (n != want) begin
                    $display("Tests file line with opcode %c has missing fields", s.op);
                    abort_run();
                end
                s.f = {v6, v5, v4, v3, v2, v1, v0};
                steps.push_back(s);
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic reset_state_check();
        count_check("hdump", '0, hdump);
        count_check("vdump", '0, vdump);
        flag_check("hs", 1'b0, hs);
        flag_check("vs", 1'b0, vs);
        flag_check("lhbl", 1'b0, lhbl);
        flag_check("lvbl", 1'b0, lvbl);
        rgb_check("rgb", '0, rgb);
    endtask

    task automatic cpu_write(input step_t s);
        cpu_wr_t w;

        w.wr     = 1'b1;
        w.target = s.f[0][0] ? pal_space : reg_space;
        w.addr   = s.f[1][9:0];
        w.data   = s.f[2][15:0];
        @(posedge clk);
        cpu <= w;
        @(posedge clk);
        cpu.wr <= 1'b0;
    endtask

    task automatic reg_read(input step_t s);
        @(posedge clk);
        rd_addr <= s.f[0][3:0];
        // Readback is combinational
        @(negedge clk);
        word_check("mmr_dout", s.f[1][15:0], mmr_dout);
    endtask

    task automatic pixel_test(input step_t s);
        layer_set_t px;
        rgb_t       exp;

        px.obj    = s.f[0][7:0];
        px.scr1   = s.f[1][7:0];
        px.scr2   = s.f[2][7:0];
        px.scr3   = s.f[3][7:0];
        exp.red   = s.f[4][7:0];
        exp.green = s.f[5][7:0];
        exp.blue  = s.f[6][7:0];
        // Keep clear of the blanking edges until the pixel reaches rgb
        @(negedge clk);
        while (!(hdump < 9'd370 && vdump < 9'd220)) begin
            @(negedge clk);
        end
        @(posedge clk);
        layers <= px;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rgb_check("rgb", exp, rgb);
    endtask

    task automatic frame_test(input step_t s);
        scan_t lhbl_cnt;
        scan_t hs_cnt;
        scan_t lvbl_lines;
        scan_t vs_lines;
        int    h_len;
        int    v_len;

        h_len      = int'(s.f[0]);
        v_len      = int'(s.f[3]);
        lvbl_lines = '0;
        vs_lines   = '0;
        // All layers transparent so the non-black backdrop feeds the blank gate
        @(posedge clk);
        layers <= '1;
        // Start on the first pixel of a frame
        @(negedge clk);
        while (!(hdump == '0 && vdump == '0)) begin
            @(negedge clk);
        end
        for (int ln = 0; ln < v_len; ln++) begin
            lhbl_cnt = '0;
            hs_cnt   = '0;
            for (int px = 0; px < h_len; px++) begin
                count_check("hdump", scan_t'(px), hdump);
                count_check("vdump", scan_t'(ln), vdump);
                if (lhbl) begin
                    lhbl_cnt = lhbl_cnt + 1'b1;
                end
                if (hs) begin
                    hs_cnt = hs_cnt + 1'b1;
                end
                // Mid-line sample, well past the blank delay
                if (px == 100) begin
                    if (lvbl) begin
                        lvbl_lines = lvbl_lines + 1'b1;
                    end
                    if (vs) begin
                        vs_lines = vs_lines + 1'b1;
                    end
                end
                if (!lhbl || !lvbl) begin
                    rgb_check("rgb", '0, rgb);
                end
                @(negedge clk);
            end
            count_check("lhbl high cycles", scan_t'(s.f[1]), lhbl_cnt);
            count_check("hs high cycles", scan_t'(s.f[2]), hs_cnt);
        end
        // Both counters wrapped back to the frame origin
        count_check("hdump", '0, hdump);
        count_check("vdump", '0, vdump);
        count_check("lvbl high lines", scan_t'(s.f[4]), lvbl_lines);
        count_check("vs high lines", scan_t'(s.f[5]), vs_lines);
    endtask

    // Watchdog
    initial begin
        cycle_cnt = 0;
        wait (limit_ready);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not complete within %0d cycles", cycle_limit);
        abort_run();
    end

    initial begin
        rst      = 1'b1;
        cpu      = '0;
        rd_addr  = '0;
        layers   = '1;
        load_tests();
        // Two frames plus a margin per test step
        cycle_limit = 2 * h_total * v_total + 600 * steps.size();
        limit_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_state_check();
        @(posedge clk);
        rst <= 1'b0;
        foreach (steps[i]) begin
            case (steps[i].op)
                "W": cpu_write(steps[i]);
                "R": reg_read(steps[i]);
                "P": pixel_test(steps[i]);
                "F": frame_test(steps[i]);
                default: begin
                end
            endcase
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* cps_video.f */
hw/cps_video_pkg.sv
hw/cps_video_timing.sv
hw/cps_mmr.sv
hw/cps_colmix.sv
hw/cps_pal.sv
hw/cps_video.sv
verif/cps_video_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal \
    --top-module cps_video_tb \
    -f cps_video.f \
    -o cps_video_sim \
    && ./obj_dir/cps_video_sim \
    || exit 1

/* verif/cps_video_tests.txt */
# W target(0 reg, 1 pal) addr data | R index expected | all fields hex
# P obj scr1 scr2 scr3 red green blue | F h_total h_active hs_width v_total v_active vs_lines
R 0 00e4
R 1 000f
R 2 0000
R f 0000
W 1 012 0f84
W 1 123 ff07
W 1 234 8123
W 1 345 3a5c
W 1 3ff 569e
W 1 150 ffff
W 1 250 0fff
W 1 050 f000
W 1 000 00ab
W 1 001 0003
R 0 00e4
R 1 000f
P 12 23 34 45 5f 2f 72
P 12 23 34 4f 0c 18 24
P 12 23 3f 4f e8 00 6c
P 12 2f 3f 4f 78 40 20
P 1f 2f 3f 4f 3f 5e 93
W 0 0 001b
W 0 1 0005
W 0 7 1234
R 0 001b
R 1 0005
R 7 0000
P 12 23 34 45 78 40 20
P 1f 23 34 45 0c 18 24
P 1f 23 3f 45 3f 5e 93
W 0 1 000f
P 1f 23 34 45 e8 00 6c
P 1f 2f 3f 45 5f 2f 72
W 0 0 0072
R 0 0072
P 12 23 34 45 e8 00 6c
P 12 2f 34 45 5f 2f 72
P 12 2f 34 4f 78 40 20
P 1f 2f 34 4f 0c 18 24
W 0 1 0008
P 12 23 34 45 5f 2f 72
P 12 23 34 4f 3f 5e 93
W 0 1 000f
P 1f 50 3f 4f e8 e8 e8
P 1f 2f 50 4f 78 78 78
P 50 2f 3f 4f 00 00 00
F 200 180 20 106 e0 3
